//--- Bender.yml
package:
  name: csr_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/riscv_csr_pkg.sv
      - common/csr_stage_pkg.sv
      - logic/csr_issue.sv
      - csr/csr_regfile.sv
      - csr/csr_trap_ctrl.sv
      - logic/csr_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/csr_stage_chk.sv
      - tb/tb_csr_stage.sv

//--- build.f
+incdir+common
common/riscv_csr_pkg.sv
common/csr_stage_pkg.sv
logic/csr_issue.sv
csr/csr_regfile.sv
csr/csr_trap_ctrl.sv
logic/csr_stage.sv
tb/csr_stage_chk.sv
tb/tb_csr_stage.sv

//--- common/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Data path width, RV32 only
`define CSR_XLEN 32

// CSR address field of the instruction
`define CSR_ADDR_W 12

// Pipeline instruction id
`define CSR_ID_W 64

// Free running counters from the core
`define CSR_CNT_W 64

// Saved id after reset, never issued by the pipeline
`define CSR_ID_NONE 64'hffff_0000_0000_0000

// MXL = 32, extensions A, I and M
`define CSR_MISA_VALUE 32'h4000_1101

`endif

//--- common/csr_stage_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package csr_stage_pkg;

    import riscv_csr_pkg::*;

    // Command decoded by the pipeline for this stage
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    // One instruction as seen by the CSR stage
    typedef struct packed {
        logic [`CSR_XLEN-1:0]   pc;
        logic [`CSR_ID_W-1:0]   inst_id;
        csr_cmd_e               cmd;
        // Raw address, may be unimplemented
        logic [`CSR_ADDR_W-1:0] addr;
        // rs1 value or zero-extended immediate
        logic [`CSR_XLEN-1:0]   operand;
        // Stores are never interrupted
        logic                   is_store;
    } csr_req_t;

    // Register file state that trap control needs
    typedef struct packed {
        priv_mode_e           mode;
        mstatus_t             mstatus;
        irq_bits_t            mie;
        irq_bits_t            mip;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
    } trap_view_t;

    // Trap decision, applied by the register file on commit
    typedef struct packed {
        logic    take_interrupt;
        logic    take_ecall;
        logic    take_mret;
        mcause_e cause;
    } trap_event_t;

endpackage

`default_nettype wire

//--- common/riscv_csr_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package riscv_csr_pkg;

    // Only user and machine mode exist
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_e;

    // Implemented CSR addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_ADDR_CYCLE     = 12'hc00,
        CSR_ADDR_TIME      = 12'hc01,
        CSR_ADDR_CYCLEH    = 12'hc80,
        CSR_ADDR_TIMEH     = 12'hc81,
        CSR_ADDR_MVENDORID = 12'hf11,
        CSR_ADDR_MARCHID   = 12'hf12,
        CSR_ADDR_MIMPID    = 12'hf13,
        CSR_ADDR_MHARTID   = 12'hf14,
        CSR_ADDR_MSTATUS   = 12'h300,
        CSR_ADDR_MISA      = 12'h301,
        CSR_ADDR_MIE       = 12'h304,
        CSR_ADDR_MTVEC     = 12'h305,
        CSR_ADDR_MSCRATCH  = 12'h340,
        CSR_ADDR_MEPC      = 12'h341,
        CSR_ADDR_MCAUSE    = 12'h342,
        CSR_ADDR_MIP       = 12'h344,
        CSR_ADDR_MCYCLE    = 12'hb00,
        CSR_ADDR_MCYCLEH   = 12'hb80
    } csr_addr_e;

    // Interrupt bit in the top position
    typedef enum logic [`CSR_XLEN-1:0] {
        MCAUSE_ECALL_U = 32'h0000_0008,
        MCAUSE_ECALL_M = 32'h0000_000b,
        MCAUSE_IRQ_SW  = 32'h8000_0003,
        MCAUSE_IRQ_TMR = 32'h8000_0007,
        MCAUSE_IRQ_EXT = 32'h8000_000b
    } mcause_e;

    // Bit positions shared by mie and mip
    localparam int IRQ_MSI_BIT = 3;
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

    // Machine interrupt lines as stored in mie and mip
    typedef struct packed {
        logic mei;
        logic mti;
        logic msi;
    } irq_bits_t;

    // Full mstatus word, unused fields stay zero
    typedef struct packed {
        logic [13:0] wpri3;
        logic        mprv;
        logic [3:0]  wpri2;
        priv_mode_e  mpp;
        logic [2:0]  wpri1;
        logic        mpie;
        logic [2:0]  wpri0;
        logic        mie;
        logic [2:0]  wpri_lo;
    } mstatus_t;

    localparam mstatus_t MSTATUS_RESET = '{
        wpri3: '0, mprv: 1'b0, wpri2: '0, mpp: PRIV_MACHINE,
        wpri1: '0, mpie: 1'b0, wpri0: '0, mie: 1'b0, wpri_lo: '0
    };

    // Keep only the implemented fields, MPP is WARL
    function automatic mstatus_t mstatus_from_word(logic [`CSR_XLEN-1:0] w);
        mstatus_t s;
        s      = MSTATUS_RESET;
        s.mprv = w[17];
        s.mpp  = (w[12:11] == 2'b11) ? PRIV_MACHINE : PRIV_USER;
        s.mpie = w[7];
        s.mie  = w[3];
        return s;
    endfunction

    function automatic logic [`CSR_XLEN-1:0] irq_to_word(irq_bits_t b);
        logic [`CSR_XLEN-1:0] w;
        w              = '0;
        w[IRQ_MEI_BIT] = b.mei;
        w[IRQ_MTI_BIT] = b.mti;
        w[IRQ_MSI_BIT] = b.msi;
        return w;
    endfunction

    function automatic irq_bits_t irq_from_word(logic [`CSR_XLEN-1:0] w);
        irq_bits_t b;
        b.mei = w[IRQ_MEI_BIT];
        b.mti = w[IRQ_MTI_BIT];
        b.msi = w[IRQ_MSI_BIT];
        return b;
    endfunction

endpackage

`default_nettype wire

//--- csr/csr_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module csr_regfile import riscv_csr_pkg::*, csr_stage_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  commit,
    input  csr_req_t              req,
    input  trap_event_t           event_in,
    input  logic [`CSR_CNT_W-1:0] mtime,
    input  logic [`CSR_CNT_W-1:0] mtimecmp,
    input  logic [`CSR_CNT_W-1:0] cycle_cnt,
    input  logic [`CSR_CNT_W-1:0] time_cnt,
    input  logic                  irq_ext,
    input  logic                  irq_sw,
    output logic [`CSR_XLEN-1:0]  rdata,
    output trap_view_t            view
);

    // Current privilege mode
    priv_mode_e           mode;

    mstatus_t             mstatus;
    irq_bits_t            mie;
    irq_bits_t            mip;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;

    logic                 can_access;
    logic                 can_write;
    logic                 is_rmw;
    logic [`CSR_XLEN-1:0] cur_val;
    logic [`CSR_XLEN-1:0] wdata;

    // Bits 9:8 give the lowest mode allowed
    assign can_access = req.addr[9:8] <= mode;
    // Bits 11:10 both set means read-only
    assign can_write  = can_access && !req.addr[10];

    assign is_rmw = (req.cmd == CMD_WRITE) || (req.cmd == CMD_SET) ||
                    (req.cmd == CMD_CLEAR);

    // Old value of the addressed CSR
    always_comb begin
        case (req.addr)
            CSR_ADDR_CYCLE, CSR_ADDR_MCYCLE:   cur_val = cycle_cnt[`CSR_XLEN-1:0];
            CSR_ADDR_CYCLEH, CSR_ADDR_MCYCLEH: cur_val = cycle_cnt[`CSR_CNT_W-1:`CSR_XLEN];
            CSR_ADDR_TIME:                     cur_val = time_cnt[`CSR_XLEN-1:0];
            CSR_ADDR_TIMEH:                    cur_val = time_cnt[`CSR_CNT_W-1:`CSR_XLEN];
            // ID registers read as zero
            CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID,
            CSR_ADDR_MIMPID, CSR_ADDR_MHARTID: cur_val = '0;
            CSR_ADDR_MSTATUS:                  cur_val = mstatus;
            CSR_ADDR_MISA:                     cur_val = `CSR_MISA_VALUE;
            CSR_ADDR_MIE:                      cur_val = irq_to_word(mie);
            CSR_ADDR_MTVEC:                    cur_val = mtvec;
            CSR_ADDR_MSCRATCH:                 cur_val = mscratch;
            CSR_ADDR_MEPC:                     cur_val = mepc;
            CSR_ADDR_MCAUSE:                   cur_val = mcause;
            CSR_ADDR_MIP:                      cur_val = irq_to_word(mip);
            default:                           cur_val = '0;
        endcase
    end

    // Write merge for csrrw, csrrs and csrrc
    always_comb begin
        case (req.cmd)
            CMD_WRITE: wdata = req.operand;
            CMD_SET:   wdata = cur_val | req.operand;
            CMD_CLEAR: wdata = cur_val & ~req.operand;
            default:   wdata = cur_val;
        endcase
    end

    // Old value returned, zero when refused
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (commit) begin
            rdata <= can_access ? cur_val : '0;
        end
    end

    // Pending lines sampled every cycle, not writable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip <= '0;
        end else begin
            mip.mei <= irq_ext;
            mip.msi <= irq_sw;
            mip.mti <= mtime >= mtimecmp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode     <= PRIV_MACHINE;
            mstatus  <= MSTATUS_RESET;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (commit) begin
            if (event_in.take_interrupt || event_in.take_ecall) begin
                // Trap entry into machine mode
                mepc         <= req.pc;
                mcause       <= event_in.cause;
                mstatus.mpp  <= mode;
                mstatus.mpie <= mstatus.mie;
                mstatus.mie  <= 1'b0;
                mode         <= PRIV_MACHINE;
            end else if (event_in.take_mret) begin
                // Return to the mode saved in MPP
                mstatus.mie  <= mstatus.mpie;
                mstatus.mpie <= 1'b1;
                mode         <= mstatus.mpp;
                mstatus.mpp  <= PRIV_USER;
                if (mstatus.mpp != PRIV_MACHINE) begin
                    mstatus.mprv <= 1'b0;
                end
            end else if (is_rmw && can_write) begin
                // misa, mip and counters ignore writes
                case (req.addr)
                    CSR_ADDR_MSTATUS:  mstatus  <= mstatus_from_word(wdata);
                    CSR_ADDR_MIE:      mie      <= irq_from_word(wdata);
                    CSR_ADDR_MTVEC:    mtvec    <= wdata;
                    CSR_ADDR_MSCRATCH: mscratch <= wdata;
                    CSR_ADDR_MEPC:     mepc     <= {wdata[`CSR_XLEN-1:2], 2'b00};
                    CSR_ADDR_MCAUSE:   mcause   <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    // State for the trap decision
    assign view = '{
        mode:    mode,
        mstatus: mstatus,
        mie:     mie,
        mip:     mip,
        mtvec:   mtvec,
        mepc:    mepc
    };

endmodule

`default_nettype wire

//--- csr/csr_trap_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module csr_trap_ctrl import riscv_csr_pkg::*, csr_stage_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid,
    input  logic                 commit,
    input  csr_req_t             req,
    input  trap_view_t           view,
    output trap_event_t          event_out,
    output logic                 irq_pending,
    output logic                 trap,
    output logic [`CSR_XLEN-1:0] trap_vector
);

    logic                 irq_global;
    logic                 irq_ext_en;
    logic                 irq_sw_en;
    logic                 irq_tmr_en;
    mcause_e              irq_cause;
    mcause_e              ecall_cause;
    logic                 take_irq;
    logic                 take_ecall;
    logic                 take_mret;
    logic                 trap_now;
    logic                 trap_hold;
    logic [`CSR_XLEN-1:0] mtvec_base;
    logic [`CSR_XLEN-1:0] irq_target;
    logic [`CSR_XLEN-1:0] next_vector;

    // User mode is always interruptible by machine interrupts
    assign irq_global = (view.mode == PRIV_USER) || view.mstatus.mie;

    assign irq_ext_en = irq_global && view.mip.mei && view.mie.mei;
    assign irq_sw_en  = irq_global && view.mip.msi && view.mie.msi;
    assign irq_tmr_en = irq_global && view.mip.mti && view.mie.mti;

    // External first, then software, then timer
    assign irq_cause = irq_ext_en ? MCAUSE_IRQ_EXT :
                       irq_sw_en  ? MCAUSE_IRQ_SW  : MCAUSE_IRQ_TMR;

    assign ecall_cause = (view.mode == PRIV_USER) ? MCAUSE_ECALL_U : MCAUSE_ECALL_M;

    // Stores must complete, so they are never interrupted
    assign irq_pending = (irq_ext_en || irq_sw_en || irq_tmr_en) && !req.is_store;

    // Interrupt wins over ecall and mret
    assign take_irq   = valid && irq_pending;
    assign take_ecall = valid && !irq_pending && (req.cmd == CMD_ECALL);
    assign take_mret  = valid && !irq_pending && (req.cmd == CMD_MRET);
    assign trap_now   = take_irq || take_ecall || take_mret;

    assign event_out = '{
        take_interrupt: take_irq,
        take_ecall:     take_ecall,
        take_mret:      take_mret,
        cause:          take_irq ? irq_cause : ecall_cause
    };

    // Low two bits of mtvec are the mode field
    assign mtvec_base = {view.mtvec[`CSR_XLEN-1:2], 2'b00};

    // Vectored mode adds 4 x cause code, interrupts only
    assign irq_target = (view.mtvec[1:0] == 2'b01) ?
                        mtvec_base + {irq_cause[`CSR_XLEN-3:0], 2'b00} : mtvec_base;

    assign next_vector = take_irq   ? irq_target :
                         take_ecall ? mtvec_base : view.mepc;

    // Trap state changes right after commit, so the decision is held
    // for the rest of the cycles of this instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_hold <= 1'b0;
        end else if (commit) begin
            trap_hold <= trap_now;
        end
    end

    assign trap = valid && (commit ? trap_now : trap_hold);

    // Target stays until the next trapping commit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_vector <= '0;
        end else if (commit && trap_now) begin
            trap_vector <= next_vector;
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module csr_issue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid,
    input  logic [`CSR_ID_W-1:0] inst_id,
    input  logic                 needs_stall,
    output logic                 commit,
    output logic                 stall
);

    // Id of the last instruction seen with valid high
    logic [`CSR_ID_W-1:0] saved_id;
    logic                 is_new;

    // New instruction only when the id changes
    assign is_new = valid && (inst_id != saved_id);

    // One commit per id, a held request never commits twice
    assign commit = is_new;

    // Pipeline waits one cycle for registered results
    assign stall = is_new && needs_stall;

    // Saved id catches up in the commit cycle
    // so the next cycle sees the same id and releases the stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_id <= `CSR_ID_NONE;
        end else if (valid) begin
            saved_id <= inst_id;
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module csr_stage import csr_stage_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  csr_valid,
    input  csr_req_t              csr_req,
    input  logic [`CSR_CNT_W-1:0] mtime,
    input  logic [`CSR_CNT_W-1:0] mtimecmp,
    input  logic [`CSR_CNT_W-1:0] cycle_cnt,
    input  logic [`CSR_CNT_W-1:0] time_cnt,
    input  logic                  irq_ext,
    input  logic                  irq_sw,
    output logic [`CSR_XLEN-1:0]  csr_rdata,
    output logic                  csr_stall,
    output logic                  csr_trap,
    output logic [`CSR_XLEN-1:0]  csr_trap_vector
);

    logic        commit;
    logic        irq_pending;
    logic        needs_stall;
    trap_view_t  view;
    trap_event_t trap_event;

    // Any command or a pending interrupt needs a registered result
    assign needs_stall = (csr_req.cmd != CMD_NONE) || irq_pending;

    csr_issue i_csr_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (csr_valid),
        .inst_id     (csr_req.inst_id),
        .needs_stall (needs_stall),
        .commit      (commit),
        .stall       (csr_stall)
    );

    csr_regfile i_csr_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit    (commit),
        .req       (csr_req),
        .event_in  (trap_event),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .cycle_cnt (cycle_cnt),
        .time_cnt  (time_cnt),
        .irq_ext   (irq_ext),
        .irq_sw    (irq_sw),
        .rdata     (csr_rdata),
        .view      (view)
    );

    csr_trap_ctrl i_csr_trap_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (csr_valid),
        .commit      (commit),
        .req         (csr_req),
        .view        (view),
        .event_out   (trap_event),
        .irq_pending (irq_pending),
        .trap        (csr_trap),
        .trap_vector (csr_trap_vector)
    );

endmodule

`default_nettype wire

//--- tb/csr_stage_chk.sv
`timescale 1ns/1ns
`default_nettype none

module csr_stage_chk import riscv_csr_pkg::*, csr_stage_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       csr_valid,
    input csr_req_t   csr_req,
    input logic       csr_stall,
    input logic       csr_trap,
    input priv_mode_e mode
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // One stall cycle per id
    stall_once: assert property (@(posedge clk) disable iff (!rst_n)
        csr_stall |=> !(csr_stall && $stable(csr_req.inst_id)))
        else begin
            fail_count++;
            $error("stall held for a second cycle on the same instruction id");
        end

    trap_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        csr_trap |-> csr_valid)
        else begin
            fail_count++;
            $error("trap flag raised without a valid request");
        end

    // Only user and machine mode exist
    mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mode inside {PRIV_USER, PRIV_MACHINE})
        else begin
            fail_count++;
            $error("privilege mode left the legal values");
        end

    no_stall_in_reset: assert property (@(posedge clk) !rst_n |-> !csr_stall)
        else begin
            fail_count++;
            $error("stall raised while in reset");
        end

endmodule

`default_nettype wire

//--- tb/tb_csr_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_settings.svh"

module tb_csr_stage import riscv_csr_pkg::*, csr_stage_pkg::*; ();

    localparam int RESET_CYCLES    = 16;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 40;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST + 64;

    localparam logic [`CSR_CNT_W-1:0] CYCLE_VALUE = 64'h0000_0012_3456_789a;
    localparam logic [`CSR_CNT_W-1:0] TIME_VALUE  = 64'h0000_0003_0000_0abc;
    localparam logic [`CSR_XLEN-1:0]  MTVEC_BASE  = 32'h0000_1000;
    // MXL 1 for RV32, extension bits A, I and M
    localparam logic [`CSR_XLEN-1:0]  MISA_EXP    = 32'h4000_0000 | (32'h1 << 0) |
                                                    (32'h1 << 8) | (32'h1 << 12);

    logic                  clk;
    logic                  rst_n;
    logic                  csr_valid;
    csr_req_t              csr_req;
    logic [`CSR_CNT_W-1:0] mtime;
    logic [`CSR_CNT_W-1:0] mtimecmp;
    logic [`CSR_CNT_W-1:0] cycle_cnt;
    logic [`CSR_CNT_W-1:0] time_cnt;
    logic                  irq_ext;
    logic                  irq_sw;
    logic [`CSR_XLEN-1:0]  csr_rdata;
    logic                  csr_stall;
    logic                  csr_trap;
    logic [`CSR_XLEN-1:0]  csr_trap_vector;

    int                    errors;
    int                    checks;
    int                    total_fail;
    int                    cycle_count = 0;
    logic [`CSR_ID_W-1:0]  next_id;
    logic [`CSR_XLEN-1:0]  next_pc;
    // Results of the last request
    logic [`CSR_XLEN-1:0]  last_pc;
    logic [`CSR_XLEN-1:0]  last_rdata;
    logic [`CSR_XLEN-1:0]  last_vector;
    logic                  last_trap;
    logic                  last_stall;
    // Expected mode and mscratch, kept by the testbench
    logic                  machine_mode;
    logic [`CSR_XLEN-1:0]  mscratch_exp;
    logic [`CSR_XLEN-1:0]  mtvec_exp;
    logic [`CSR_XLEN-1:0]  ecall_pc;

    csr_stage i_csr_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_valid       (csr_valid),
        .csr_req         (csr_req),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .cycle_cnt       (cycle_cnt),
        .time_cnt        (time_cnt),
        .irq_ext         (irq_ext),
        .irq_sw          (irq_sw),
        .csr_rdata       (csr_rdata),
        .csr_stall       (csr_stall),
        .csr_trap        (csr_trap),
        .csr_trap_vector (csr_trap_vector)
    );

    // Mode comes from the view bus inside the top level
    bind csr_stage csr_stage_chk i_csr_stage_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_valid (csr_valid),
        .csr_req   (csr_req),
        .csr_stall (csr_stall),
        .csr_trap  (csr_trap),
        .mode      (view.mode)
    );

    // 8 ns period
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_data(input string name, input logic [`CSR_XLEN-1:0] got,
                              input logic [`CSR_XLEN-1:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Reads depend only on bits 9:8 against the mode
    function automatic logic [`CSR_XLEN-1:0] expected_read(input logic [`CSR_ADDR_W-1:0] addr,
                                                          input logic [`CSR_XLEN-1:0] value);
        logic [1:0] level;
        level = machine_mode ? 2'b11 : 2'b00;
        if (addr[9:8] <= level) begin
            return value;
        end
        return '0;
    endfunction

    // One instruction with a fresh id, held until the stall drops
    task automatic issue_req(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`CSR_XLEN-1:0] operand, input logic is_store);
        csr_req_t req;
        next_id      = next_id + 1;
        next_pc      = next_pc + 4;
        req.pc       = next_pc;
        req.inst_id  = next_id;
        req.cmd      = cmd;
        req.addr     = addr;
        req.operand  = operand;
        req.is_store = is_store;
        last_pc      = next_pc;
        @(posedge clk);
        csr_valid <= 1'b1;
        csr_req   <= req;
        // Commit cycle, trap flag is combinational here
        @(negedge clk);
        last_trap  = csr_trap;
        last_stall = csr_stall;
        // Every real command waits for its registered result
        if (cmd != CMD_NONE) begin
            check_flag("csr_stall", last_stall, 1'b1);
        end
        // Registered results once the stall is gone
        do begin
            @(negedge clk);
        end while (csr_stall);
        last_rdata  = csr_rdata;
        last_vector = csr_trap_vector;
        @(posedge clk);
        csr_valid <= 1'b0;
    endtask

    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr);
        // csrrs with a zero operand
        issue_req(CMD_SET, addr, '0, 1'b0);
    endtask

    task automatic drive_irq_inputs(input logic ext, input logic sw,
                                    input logic [`CSR_CNT_W-1:0] time_now,
                                    input logic [`CSR_CNT_W-1:0] time_cmp);
        @(posedge clk);
        irq_ext  <= ext;
        irq_sw   <= sw;
        mtime    <= time_now;
        mtimecmp <= time_cmp;
    endtask

    // Write, set, clear and read back with random operands
    task automatic rmw_sequence(input logic [`CSR_ADDR_W-1:0] addr, input string name,
                                input logic [`CSR_XLEN-1:0] start_val,
                                output logic [`CSR_XLEN-1:0] final_val);
        logic [`CSR_XLEN-1:0] op;
        logic [`CSR_XLEN-1:0] exp;
        exp = start_val;
        op  = $urandom();
        issue_req(CMD_WRITE, addr, op, 1'b0);
        check_data({name, " old before write"}, last_rdata, exp);
        exp = op;
        op  = $urandom();
        issue_req(CMD_SET, addr, op, 1'b0);
        check_data({name, " old before set"}, last_rdata, exp);
        exp = exp | op;
        op  = $urandom();
        issue_req(CMD_CLEAR, addr, op, 1'b0);
        check_data({name, " old before clear"}, last_rdata, exp);
        exp = exp & ~op;
        read_csr(addr);
        check_data({name, " merged"}, last_rdata, exp);
        final_val = exp;
    endtask

    task automatic reset_values();
        read_csr(CSR_ADDR_MSTATUS);
        // Only MPP = machine after reset
        check_data("mstatus", last_rdata, 32'h0000_1800);
        read_csr(CSR_ADDR_MISA);
        check_data("misa", last_rdata, MISA_EXP);
        read_csr(CSR_ADDR_MVENDORID);
        check_data("mvendorid", last_rdata, 32'h0);
        read_csr(CSR_ADDR_CYCLE);
        check_data("cycle", last_rdata, expected_read(CSR_ADDR_CYCLE, CYCLE_VALUE[31:0]));
        read_csr(CSR_ADDR_TIME);
        check_data("time", last_rdata, expected_read(CSR_ADDR_TIME, TIME_VALUE[31:0]));
        read_csr(CSR_ADDR_CYCLEH);
        check_data("cycleh", last_rdata, expected_read(CSR_ADDR_CYCLEH, CYCLE_VALUE[63:32]));
    endtask

    task automatic csr_commands();
        rmw_sequence(CSR_ADDR_MSCRATCH, "mscratch", '0, mscratch_exp);
        rmw_sequence(CSR_ADDR_MTVEC, "mtvec", '0, mtvec_exp);
        // Low two bits of mepc always clear
        issue_req(CMD_WRITE, CSR_ADDR_MEPC, 32'h1234_5677, 1'b0);
        read_csr(CSR_ADDR_MEPC);
        check_data("mepc", last_rdata, 32'h1234_5674);
        issue_req(CMD_WRITE, CSR_ADDR_MISA, 32'h0, 1'b0);
        read_csr(CSR_ADDR_MISA);
        check_data("misa after write", last_rdata, MISA_EXP);
        issue_req(CMD_WRITE, CSR_ADDR_MIP, 32'hffff_ffff, 1'b0);
        read_csr(CSR_ADDR_MIP);
        check_data("mip after write", last_rdata, 32'h0);
        issue_req(CMD_WRITE, CSR_ADDR_MTVEC, MTVEC_BASE, 1'b0);
        check_data("mtvec old", last_rdata, mtvec_exp);
    endtask

    task automatic machine_mret();
        issue_req(CMD_ECALL, '0, '0, 1'b0);
        check_flag("csr_trap machine ecall", last_trap, 1'b1);
        check_data("csr_trap_vector machine ecall", last_vector, MTVEC_BASE);
        issue_req(CMD_WRITE, CSR_ADDR_MEPC, 32'h0000_2000, 1'b0);
        // MPP back to user
        issue_req(CMD_CLEAR, CSR_ADDR_MSTATUS, 32'h0000_1800, 1'b0);
        check_data("mstatus after ecall", last_rdata, 32'h0000_1800);
        issue_req(CMD_MRET, '0, '0, 1'b0);
        check_flag("csr_trap mret", last_trap, 1'b1);
        check_data("csr_trap_vector mret", last_vector, 32'h0000_2000);
        machine_mode = 1'b0;
        read_csr(CSR_ADDR_MSCRATCH);
        check_data("mscratch user", last_rdata, expected_read(CSR_ADDR_MSCRATCH, mscratch_exp));
        issue_req(CMD_WRITE, CSR_ADDR_MSCRATCH, 32'hdead_beef, 1'b0);
        read_csr(CSR_ADDR_CYCLE);
        check_data("cycle user", last_rdata, expected_read(CSR_ADDR_CYCLE, CYCLE_VALUE[31:0]));
    endtask

    task automatic user_ecall();
        issue_req(CMD_ECALL, '0, '0, 1'b0);
        ecall_pc = last_pc;
        check_flag("csr_trap user ecall", last_trap, 1'b1);
        check_data("csr_trap_vector user ecall", last_vector, MTVEC_BASE);
        machine_mode = 1'b1;
        read_csr(CSR_ADDR_MCAUSE);
        check_data("mcause user ecall", last_rdata, 32'h0000_0008);
        read_csr(CSR_ADDR_MEPC);
        check_data("mepc user ecall", last_rdata, ecall_pc);
        // User write must not have landed
        read_csr(CSR_ADDR_MSCRATCH);
        check_data("mscratch machine", last_rdata, mscratch_exp);
        issue_req(CMD_ECALL, '0, '0, 1'b0);
        check_flag("csr_trap machine ecall", last_trap, 1'b1);
        read_csr(CSR_ADDR_MCAUSE);
        check_data("mcause machine ecall", last_rdata, 32'h0000_000b);
    endtask

    task automatic timer_interrupt();
        // Vectored mode
        issue_req(CMD_WRITE, CSR_ADDR_MTVEC, MTVEC_BASE | 32'h1, 1'b0);
        issue_req(CMD_WRITE, CSR_ADDR_MIE, 32'h0000_0080, 1'b0);
        drive_irq_inputs(1'b0, 1'b0, 64'h200, 64'h100);
        issue_req(CMD_SET, CSR_ADDR_MSTATUS, 32'h0000_0008, 1'b0);
        check_flag("csr_trap enabling MIE", last_trap, 1'b0);
        issue_req(CMD_NONE, '0, '0, 1'b1);
        check_flag("csr_trap store", last_trap, 1'b0);
        check_flag("csr_stall store", last_stall, 1'b0);
        issue_req(CMD_NONE, '0, '0, 1'b0);
        check_flag("csr_trap timer", last_trap, 1'b1);
        check_flag("csr_stall timer", last_stall, 1'b1);
        check_data("csr_trap_vector timer", last_vector, MTVEC_BASE + 4 * 7);
        read_csr(CSR_ADDR_MCAUSE);
        check_data("mcause timer", last_rdata, 32'h8000_0007);
        drive_irq_inputs(1'b0, 1'b0, 64'h0, 64'h100);
    endtask

    task automatic irq_priority();
        drive_irq_inputs(1'b1, 1'b1, 64'h200, 64'h100);
        issue_req(CMD_WRITE, CSR_ADDR_MIE, 32'h0000_0888, 1'b0);
        issue_req(CMD_SET, CSR_ADDR_MSTATUS, 32'h0000_0008, 1'b0);
        check_flag("csr_trap enabling MIE", last_trap, 1'b0);
        issue_req(CMD_NONE, '0, '0, 1'b0);
        check_flag("csr_trap three pending", last_trap, 1'b1);
        check_flag("csr_stall three pending", last_stall, 1'b1);
        check_data("csr_trap_vector external", last_vector, MTVEC_BASE + 4 * 11);
        read_csr(CSR_ADDR_MCAUSE);
        check_data("mcause external", last_rdata, 32'h8000_000b);
        drive_irq_inputs(1'b0, 1'b0, 64'h0, 64'h100);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        csr_valid    = 1'b0;
        csr_req      = '0;
        mtime        = '0;
        // Far ahead so the timer stays quiet
        mtimecmp     = '1;
        cycle_cnt    = CYCLE_VALUE;
        time_cnt     = TIME_VALUE;
        irq_ext      = 1'b0;
        irq_sw       = 1'b0;
        errors       = 0;
        checks       = 0;
        next_id      = '0;
        next_pc      = 32'h0000_0100;
        machine_mode = 1'b1;
        void'($urandom(32'h2f8b_320e));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        csr_commands();
        machine_mret();
        user_ecall();
        timer_interrupt();
        irq_priority();
        repeat (4) @(posedge clk);
        total_fail = errors + i_csr_stage.i_csr_stage_chk.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_csr_stage.i_csr_stage_chk.fail_count);
        if (total_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
